//--- Makefile
SRCS := $(wildcard logic/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/dfdTb
	@out=$$(./obj_dir/dfdTb); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

obj_dir/dfdTb: $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal \
	  -f tb.f --top-module dfdTb -Mdir obj_dir -o dfdTb

clean:
	rm -rf obj_dir

//--- logic/dfdRegs.sv
// **********************************************************
// APB register block, zero wait states, unmapped -> PSLVERR
// Reading RDDATA advances the read index after the access
// **********************************************************
`timescale 1ns/100ps

module dfdRegs #(
  parameter int NumCores = 2,
  parameter int BufDepth = traceCfgPkg::DefaultBufDepth,
  localparam int IdxWidth = $clog2(BufDepth)
) (
  input  logic                                 i_clk,
  input  logic                                 i_arstN,
  input  logic [traceCfgPkg::ApbAddrWidth-1:0] i_paddr,
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [traceCfgPkg::ApbDataWidth-1:0] i_pwdata,
  output logic                                 o_pready,
  output logic [traceCfgPkg::ApbDataWidth-1:0] o_prdata,
  output logic                                 o_pslverr,
  input  logic [IdxWidth-1:0]                  i_writePtr,
  input  logic                                 i_wrapped,
  input  logic [NumCores-1:0]                  i_overflow,
  input  tracePktPkg::tracePkt_t               i_rdEntry,
  output traceCfgPkg::ctrl_t                   o_ctrl,
  output logic [IdxWidth-1:0]                  o_rdIdx,
  output logic                                 o_clear
);

  localparam int CoreBits = traceCfgPkg::MaxCores;
  localparam logic [CoreBits-1:0] CoreMask = CoreBits'((1 << NumCores) - 1);

  logic                 access;
  logic                 wrEn;
  logic                 rdEn;
  logic                 mapped;
  traceCfgPkg::ctrl_t   wrCtrl;
  traceCfgPkg::status_t status;

  assign access = i_psel & i_penable;
  assign wrEn   = access & i_pwrite;
  assign rdEn   = access & ~i_pwrite;
  assign wrCtrl = traceCfgPkg::ctrl_t'(i_pwdata);

  assign mapped = (i_paddr == traceCfgPkg::RegCtrl)   || (i_paddr == traceCfgPkg::RegStatus) ||
                  (i_paddr == traceCfgPkg::RegRdIdx)  || (i_paddr == traceCfgPkg::RegRdData) ||
                  (i_paddr == traceCfgPkg::RegClear);

  assign o_pready  = access;
  assign o_pslverr = access & ~mapped;
  assign o_clear   = wrEn & (i_paddr == traceCfgPkg::RegClear);

  always_comb begin
    status = '0;
    status.writePtr[IdxWidth-1:0] = i_writePtr;
    status.wrapped                = i_wrapped;
    status.overflow[NumCores-1:0] = i_overflow;
  end

  // Read mux
  always_comb begin
    o_prdata = '0;
    if (rdEn) begin
      case (i_paddr)
        traceCfgPkg::RegCtrl:   o_prdata = o_ctrl;
        traceCfgPkg::RegStatus: o_prdata = status;
        traceCfgPkg::RegRdIdx:  o_prdata[IdxWidth-1:0] = o_rdIdx;
        traceCfgPkg::RegRdData: o_prdata = i_rdEntry;
        default:                o_prdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_ctrl  <= '0;
      o_rdIdx <= '0;
    end else begin
      if (wrEn && (i_paddr == traceCfgPkg::RegCtrl)) begin
        o_ctrl.enable     <= wrCtrl.enable;
        o_ctrl.stallMode  <= wrCtrl.stallMode;
        o_ctrl.coreEnable <= wrCtrl.coreEnable & CoreMask;
      end
      if (wrEn && (i_paddr == traceCfgPkg::RegRdIdx)) begin
        o_rdIdx <= i_pwdata[IdxWidth-1:0];
      end else if (rdEn && (i_paddr == traceCfgPkg::RegRdData)) begin
        o_rdIdx <= o_rdIdx + 1'b1;
      end
    end
  end

endmodule

//--- logic/dfdTop.sv
// **********************************************************
// Trace collector top, NumCores from 1 to 4
// Start/stop pulses and retire reports come one per core
// **********************************************************
`timescale 1ns/100ps

module dfdTop #(
  parameter int NumCores = 2,
  parameter int Credits  = traceCfgPkg::DefaultCredits,
  parameter int BufDepth = traceCfgPkg::DefaultBufDepth
) (
  input  logic                                  i_clk,
  input  logic                                  i_arstN,
  input  logic [traceCfgPkg::ApbAddrWidth-1:0]  i_paddr,
  input  logic                                  i_psel,
  input  logic                                  i_penable,
  input  logic                                  i_pwrite,
  input  logic [traceCfgPkg::ApbDataWidth-1:0]  i_pwdata,
  output logic                                  o_pready,
  output logic [traceCfgPkg::ApbDataWidth-1:0]  o_prdata,
  output logic                                  o_pslverr,
  input  logic [NumCores-1:0]                   i_traceStart,
  input  logic [NumCores-1:0]                   i_traceStop,
  input  tracePktPkg::retire_t [NumCores-1:0]   i_retire,
  output logic [NumCores-1:0]                   o_backpressure,
  output logic [NumCores-1:0]                   o_active
);

  localparam int IdxWidth = $clog2(BufDepth);

  traceCfgPkg::ctrl_t                    ctrl;
  logic                                  clear;
  logic [IdxWidth-1:0]                   rdIdx;
  logic [IdxWidth-1:0]                   writePtr;
  logic                                  wrapped;
  logic [NumCores-1:0]                   overflow;
  tracePktPkg::tracePkt_t                rdEntry;
  tracePktPkg::tracePkt_t [NumCores-1:0] encPkt;
  logic [NumCores-1:0]                   encValid;
  logic [NumCores-1:0]                   credit;
  tracePktPkg::tracePkt_t                funnelPkt;
  logic                                  funnelValid;

  dfdRegs #(
    .NumCores(NumCores),
    .BufDepth(BufDepth)
  ) u_regs (
    .i_clk     (i_clk),
    .i_arstN   (i_arstN),
    .i_paddr   (i_paddr),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_pwdata  (i_pwdata),
    .o_pready  (o_pready),
    .o_prdata  (o_prdata),
    .o_pslverr (o_pslverr),
    .i_writePtr(writePtr),
    .i_wrapped (wrapped),
    .i_overflow(overflow),
    .i_rdEntry (rdEntry),
    .o_ctrl    (ctrl),
    .o_rdIdx   (rdIdx),
    .o_clear   (clear)
  );

  // ********************************************************
  // One encoder per core
  // ********************************************************
  for (genvar c = 0; c < NumCores; c++) begin : g_enc
    traceEncoder #(
      .Credits(Credits)
    ) u_enc (
      .i_clk         (i_clk),
      .i_arstN       (i_arstN),
      .i_coreId      (2'(c)),
      .i_ctrl        (ctrl),
      .i_clear       (clear),
      .i_start       (i_traceStart[c]),
      .i_stop        (i_traceStop[c]),
      .i_retire      (i_retire[c]),
      .i_credit      (credit[c]),
      .o_pkt         (encPkt[c]),
      .o_pktValid    (encValid[c]),
      .o_backpressure(o_backpressure[c]),
      .o_active      (o_active[c]),
      .o_overflow    (overflow[c])
    );
  end

  traceFunnel #(
    .NumCores(NumCores),
    .Credits (Credits)
  ) u_funnel (
    .i_clk     (i_clk),
    .i_arstN   (i_arstN),
    .i_pkt     (encPkt),
    .i_pktValid(encValid),
    .o_credit  (credit),
    .o_pkt     (funnelPkt),
    .o_pktValid(funnelValid)
  );

  traceSink #(
    .BufDepth(BufDepth)
  ) u_sink (
    .i_clk     (i_clk),
    .i_arstN   (i_arstN),
    .i_clear   (clear),
    .i_pkt     (funnelPkt),
    .i_pktValid(funnelValid),
    .i_rdIdx   (rdIdx),
    .o_rdEntry (rdEntry),
    .o_writePtr(writePtr),
    .o_wrapped (wrapped)
  );

endmodule

//--- logic/traceCfgPkg.sv
// **********************************************************
// Register map and control/status layouts for the collector
// Supports at most MaxCores cores and a 16 bit write pointer
// **********************************************************

package traceCfgPkg;

  localparam int ApbAddrWidth = 12;
  localparam int ApbDataWidth = 32;

  // Sizing limits and defaults
  localparam int MaxCores        = 4;
  localparam int DefaultCredits  = 4;
  localparam int DefaultBufDepth = 64;

  localparam logic [ApbAddrWidth-1:0] RegCtrl   = 12'h000;
  localparam logic [ApbAddrWidth-1:0] RegStatus = 12'h004;
  localparam logic [ApbAddrWidth-1:0] RegRdIdx  = 12'h008;
  localparam logic [ApbAddrWidth-1:0] RegRdData = 12'h00C;
  localparam logic [ApbAddrWidth-1:0] RegClear  = 12'h010;

  // Bit 0 global enable, bit 1 stall mode, bits 5:2 per-core enables
  typedef struct packed {
    logic [25:0]         rsvd;
    logic [MaxCores-1:0] coreEnable;
    logic                stallMode;
    logic                enable;
  } ctrl_t;

  typedef struct packed {
    logic [10:0]         rsvd;
    logic [MaxCores-1:0] overflow;
    logic                wrapped;
    logic [15:0]         writePtr;
  } status_t;

endpackage

//--- logic/traceEncoder.sv
// **********************************************************
// Per-core encoder, sends only while holding a funnel credit
// Markers go out before any instruction packet
// **********************************************************
`timescale 1ns/100ps

module traceEncoder #(
  parameter int Credits = traceCfgPkg::DefaultCredits
) (
  input  logic                   i_clk,
  input  logic                   i_arstN,
  input  logic [1:0]             i_coreId,
  input  traceCfgPkg::ctrl_t     i_ctrl,
  input  logic                   i_clear,
  input  logic                   i_start,
  input  logic                   i_stop,
  input  tracePktPkg::retire_t   i_retire,
  input  logic                   i_credit,
  output tracePktPkg::tracePkt_t o_pkt,
  output logic                   o_pktValid,
  output logic                   o_backpressure,
  output logic                   o_active,
  output logic                   o_overflow
);

  localparam int CntWidth = $clog2(Credits + 1);

  logic [CntWidth-1:0]    creditCnt;
  logic                   startPend;
  logic                   stopPend;
  logic                   enabled;
  logic                   hasCredit;
  logic                   markerPend;
  logic                   sendStart;
  logic                   sendStop;
  logic                   sendInstr;
  logic                   send;
  logic                   retireLost;
  tracePktPkg::tracePkt_t nextPkt;

  assign enabled    = i_ctrl.enable & i_ctrl.coreEnable[i_coreId];
  assign hasCredit  = (creditCnt != '0);
  assign markerPend = startPend | stopPend;

  // Start marker first, then stop, then instructions
  assign sendStart  = hasCredit & startPend;
  assign sendStop   = hasCredit & stopPend & ~startPend;
  assign sendInstr  = hasCredit & ~markerPend & o_active & i_retire.valid;
  assign send       = sendStart | sendStop | sendInstr;
  assign retireLost = o_active & i_retire.valid & ~sendInstr;

  assign o_backpressure = i_ctrl.stallMode & o_active & (~hasCredit | markerPend);

  always_comb begin
    nextPkt        = '0;
    nextPkt.coreId = i_coreId;
    if (sendStart) begin
      nextPkt.kind = tracePktPkg::KindStart;
    end else if (sendStop) begin
      nextPkt.kind = tracePktPkg::KindStop;
    end else begin
      nextPkt.kind  = tracePktPkg::KindInstr;
      nextPkt.iType = i_retire.iType;
      nextPkt.iAddr = i_retire.iAddr;
    end
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_active   <= 1'b0;
      startPend  <= 1'b0;
      stopPend   <= 1'b0;
      creditCnt  <= CntWidth'(Credits);
      o_pktValid <= 1'b0;
      o_overflow <= 1'b0;
    end else begin
      if (sendStart) startPend <= 1'b0;
      if (sendStop) stopPend <= 1'b0;
      // A new start waits until the previous stop marker is out
      if (i_start && enabled && !o_active && !stopPend) begin
        o_active  <= 1'b1;
        startPend <= 1'b1;
      end else if (i_stop && o_active) begin
        o_active <= 1'b0;
        stopPend <= 1'b1;
      end
      creditCnt  <= creditCnt - CntWidth'(send) + CntWidth'(i_credit);
      o_pktValid <= send;
      if (i_clear) begin
        o_overflow <= 1'b0;
      end else if (retireLost && !i_ctrl.stallMode) begin
        o_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (send) o_pkt <= nextPkt;
  end

endmodule

//--- logic/traceFunnel.sv
// **********************************************************
// Credit-based funnel, one FIFO of depth Credits per source
// Round-robin pop, at most one packet per cycle to the sink
// **********************************************************
`timescale 1ns/100ps

module traceFunnel #(
  parameter int NumCores = 2,
  parameter int Credits  = traceCfgPkg::DefaultCredits
) (
  input  logic                                  i_clk,
  input  logic                                  i_arstN,
  input  tracePktPkg::tracePkt_t [NumCores-1:0] i_pkt,
  input  logic [NumCores-1:0]                   i_pktValid,
  output logic [NumCores-1:0]                   o_credit,
  output tracePktPkg::tracePkt_t                o_pkt,
  output logic                                  o_pktValid
);

  localparam int PtrWidth = (Credits > 1) ? $clog2(Credits) : 1;
  localparam int CntWidth = $clog2(Credits + 1);
  localparam int SelWidth = (NumCores > 1) ? $clog2(NumCores) : 1;

  tracePktPkg::tracePkt_t            fifoMem [NumCores][Credits];
  logic [NumCores-1:0][PtrWidth-1:0] wrPtr;
  logic [NumCores-1:0][PtrWidth-1:0] rdPtr;
  logic [NumCores-1:0][CntWidth-1:0] fifoCnt;
  logic [NumCores-1:0]               notEmpty;
  logic [NumCores-1:0]               popSel;
  logic [SelWidth-1:0]               popIdx;
  logic [SelWidth-1:0]               rrLast;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Credits - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ********************************************************
  // Round-robin pick, starting after the last source served
  // ********************************************************
  always_comb begin
    int idx;
    for (int s = 0; s < NumCores; s++) begin
      notEmpty[s] = (fifoCnt[s] != '0);
    end
    popSel = '0;
    popIdx = rrLast;
    for (int i = 1; i <= NumCores; i++) begin
      idx = (int'(rrLast) + i) % NumCores;
      if (notEmpty[idx] && (popSel == '0)) begin
        popSel[idx] = 1'b1;
        popIdx      = SelWidth'(idx);
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      wrPtr      <= '0;
      rdPtr      <= '0;
      fifoCnt    <= '0;
      rrLast     <= '0;
      o_credit   <= '0;
      o_pktValid <= 1'b0;
    end else begin
      for (int s = 0; s < NumCores; s++) begin
        if (i_pktValid[s]) wrPtr[s] <= nextPtr(wrPtr[s]);
        if (popSel[s]) rdPtr[s] <= nextPtr(rdPtr[s]);
        fifoCnt[s] <= fifoCnt[s] + CntWidth'(i_pktValid[s]) - CntWidth'(popSel[s]);
      end
      if (popSel != '0) rrLast <= popIdx;
      // Credit goes back to the source that was popped
      o_credit   <= popSel;
      o_pktValid <= |popSel;
    end
  end

  always_ff @(posedge i_clk) begin
    for (int s = 0; s < NumCores; s++) begin
      if (i_pktValid[s]) fifoMem[s][wrPtr[s]] <= i_pkt[s];
    end
    if (|popSel) o_pkt <= fifoMem[popIdx][rdPtr[popIdx]];
  end

endmodule

//--- logic/tracePktPkg.sv
// **********************************************************
// Retire report and 32 bit trace packet formats
// Marker packets carry zero iType and iAddr
// **********************************************************

package tracePktPkg;

  typedef enum logic [1:0] {
    KindStart = 2'd1,
    KindInstr = 2'd2,
    KindStop  = 2'd3
  } pktKind_e;

  // iAddr holds instruction address bits 24:1
  typedef struct packed {
    logic        valid;
    logic [3:0]  iType;
    logic [23:0] iAddr;
  } retire_t;

  typedef struct packed {
    logic [1:0]  coreId;
    pktKind_e    kind;
    logic [3:0]  iType;
    logic [23:0] iAddr;
  } tracePkt_t;

endpackage

//--- logic/traceSink.sv
// **********************************************************
// Circular trace buffer, BufDepth must be a power of two
// Oldest entries are overwritten once the pointer wraps
// **********************************************************
`timescale 1ns/100ps

module traceSink #(
  parameter int BufDepth = traceCfgPkg::DefaultBufDepth,
  localparam int IdxWidth = $clog2(BufDepth)
) (
  input  logic                   i_clk,
  input  logic                   i_arstN,
  input  logic                   i_clear,
  input  tracePktPkg::tracePkt_t i_pkt,
  input  logic                   i_pktValid,
  input  logic [IdxWidth-1:0]    i_rdIdx,
  output tracePktPkg::tracePkt_t o_rdEntry,
  output logic [IdxWidth-1:0]    o_writePtr,
  output logic                   o_wrapped
);

  tracePktPkg::tracePkt_t traceBuf [BufDepth];

  always_ff @(posedge i_clk) begin
    if (i_pktValid) traceBuf[o_writePtr] <= i_pkt;
  end

  // Pointer and wrap flag, clear takes priority
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_writePtr <= '0;
      o_wrapped  <= 1'b0;
    end else if (i_clear) begin
      o_writePtr <= '0;
      o_wrapped  <= 1'b0;
    end else if (i_pktValid) begin
      o_writePtr <= o_writePtr + 1'b1;
      if (o_writePtr == '1) o_wrapped <= 1'b1;
    end
  end

  assign o_rdEntry = traceBuf[i_rdIdx];

endmodule

//--- tb.f
logic/traceCfgPkg.sv
logic/tracePktPkg.sv
logic/dfdRegs.sv
logic/traceEncoder.sv
logic/traceFunnel.sv
logic/traceSink.sv
logic/dfdTop.sv
testbench/dfdTop_checker.sv
testbench/dfdTb.sv

//--- testbench/dfdTb.sv
// **********************************************************
// Directed testbench for dfdTop, two cores, 64 entry buffer
// Run ends on a 20000 cycle timeout
// **********************************************************
`timescale 1ns/100ps

module dfdTb;

  localparam int NumCores = 2;
  localparam int BufDepth = 64;
  localparam int TimeoutCycles = 20000;

  logic                               clk;
  logic                               arstN;
  logic [11:0]                        paddr;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [31:0]                        pwdata;
  logic                               pready;
  logic [31:0]                        prdata;
  logic                               pslverr;
  logic [NumCores-1:0]                traceStart;
  logic [NumCores-1:0]                traceStop;
  tracePktPkg::retire_t [NumCores-1:0] retire;
  logic [NumCores-1:0]                bp;
  logic [NumCores-1:0]                active;

  int errors;
  int checks;
  int testsRun;
  int cycles;
  int seed;
  tracePktPkg::tracePkt_t got[$];
  tracePktPkg::tracePkt_t expQ[$];

  dfdTop #(
    .NumCores(NumCores),
    .Credits (4),
    .BufDepth(BufDepth)
  ) u_dut (
    .i_clk         (clk),
    .i_arstN       (arstN),
    .i_paddr       (paddr),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr),
    .i_traceStart  (traceStart),
    .i_traceStop   (traceStop),
    .i_retire      (retire),
    .o_backpressure(bp),
    .o_active      (active)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: run exceeded %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // **********************************************************
  // Helpers
  // **********************************************************
  task automatic expectEq(input string name, input logic [31:0] gotVal, input logic [31:0] expVal);
    checks++;
    if (gotVal !== expVal) begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expVal, gotVal);
    end
  endtask

  task automatic apbAccess(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwdata  <= data;
    pwrite  <= wr;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      errors++;
      $display("APB access to %h saw no PREADY in the access phase", addr);
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic writeReg(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apbAccess(1'b1, addr, data, unused, err);
    expectEq("pslverr", 32'(err), 32'd0);
  endtask

  task automatic readReg(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apbAccess(1'b0, addr, 32'd0, data, err);
    expectEq("pslverr", 32'(err), 32'd0);
  endtask

  task automatic pulseTrace(input logic isStop, input logic [NumCores-1:0] mask);
    @(posedge clk);
    if (isStop) traceStop <= mask;
    else traceStart <= mask;
    @(posedge clk);
    traceStart <= '0;
    traceStop  <= '0;
  endtask

  function automatic tracePktPkg::retire_t mkRetire(input logic [3:0] t, input logic [23:0] a);
    tracePktPkg::retire_t r;
    r.valid = 1'b1;
    r.iType = t;
    r.iAddr = a;
    return r;
  endfunction

  function automatic tracePktPkg::tracePkt_t mkPkt(input int core, input tracePktPkg::pktKind_e k,
                                                   input logic [3:0] t, input logic [23:0] a);
    tracePktPkg::tracePkt_t p;
    p.coreId = 2'(core);
    p.kind   = k;
    p.iType  = t;
    p.iAddr  = a;
    return p;
  endfunction

  function automatic logic [3:0] typeOf(input int core, input int i);
    return 4'(i * 3 + core * 7 + 1);
  endfunction

  function automatic logic [23:0] addrOf(input int core, input int i);
    return 24'(32'h00A000 + core * 32'h010000 + i * 32'h12);
  endfunction

  // Holds each report until that core's backpressure is low
  task automatic driveRetires(input logic [NumCores-1:0] mask, input int i);
    logic [NumCores-1:0] pend;
    logic [NumCores-1:0] done;
    pend = mask;
    @(posedge clk);
    for (int c = 0; c < NumCores; c++) begin
      if (mask[c]) retire[c] <= mkRetire(typeOf(c, i), addrOf(c, i));
    end
    while (pend != '0) begin
      @(negedge clk);
      done = pend & ~bp;
      @(posedge clk);
      for (int c = 0; c < NumCores; c++) begin
        if (done[c]) retire[c] <= '0;
      end
      pend = pend & ~done;
    end
  endtask

  task automatic waitWritePtr(input int expPtr, input logic expWrap);
    logic [31:0]          d;
    traceCfgPkg::status_t st;
    do begin
      readReg(traceCfgPkg::RegStatus, d);
      st = traceCfgPkg::status_t'(d);
    end while (!((int'(st.writePtr) == expPtr) && (st.wrapped == expWrap)));
  endtask

  // Settled once four status reads in a row agree
  task automatic waitSettled(output traceCfgPkg::status_t st);
    logic [31:0] d;
    logic [31:0] last;
    int          same;
    same = 0;
    readReg(traceCfgPkg::RegStatus, last);
    while (same < 4) begin
      readReg(traceCfgPkg::RegStatus, d);
      if (d == last) same++;
      else same = 0;
      last = d;
    end
    st = traceCfgPkg::status_t'(last);
  endtask

  task automatic readBuffer(input int count);
    logic [31:0] d;
    got.delete();
    writeReg(traceCfgPkg::RegRdIdx, 32'd0);
    for (int i = 0; i < count; i++) begin
      readReg(traceCfgPkg::RegRdData, d);
      got.push_back(tracePktPkg::tracePkt_t'(d));
    end
  endtask

  task automatic buildExpected(input int core, input int n);
    expQ.delete();
    expQ.push_back(mkPkt(core, tracePktPkg::KindStart, 4'd0, 24'd0));
    for (int i = 0; i < n; i++) begin
      expQ.push_back(mkPkt(core, tracePktPkg::KindInstr, typeOf(core, i), addrOf(core, i)));
    end
    expQ.push_back(mkPkt(core, tracePktPkg::KindStop, 4'd0, 24'd0));
  endtask

  task automatic checkCore(input int core);
    tracePktPkg::tracePkt_t mine[$];
    foreach (got[k]) begin
      if (int'(got[k].coreId) == core) mine.push_back(got[k]);
    end
    expectEq("core packet count", 32'(mine.size()), 32'(expQ.size()));
    for (int k = 0; k < mine.size() && k < expQ.size(); k++) begin
      expectEq("rdEntry", mine[k], expQ[k]);
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testsRun++;
    if (errors == errBefore) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errBefore);
  endtask

  // **********************************************************
  // Tests
  // **********************************************************
  task automatic testRegisters();
    int          e0;
    logic [31:0] d;
    logic        err;
    logic [11:0] addr;
    e0 = errors;
    readReg(traceCfgPkg::RegCtrl, d);
    expectEq("CTRL reset", d, 32'd0);
    readReg(traceCfgPkg::RegStatus, d);
    expectEq("STATUS reset", d, 32'd0);
    // Core enables above NumCores read back as zero
    writeReg(traceCfgPkg::RegCtrl, 32'h3F);
    readReg(traceCfgPkg::RegCtrl, d);
    expectEq("CTRL", d, 32'h0F);
    addr = 12'($random(seed));
    if (addr <= 12'h010) addr = addr | 12'h800;
    apbAccess(1'b1, addr, 32'h0, d, err);
    expectEq("pslverr unmapped write", 32'(err), 32'd1);
    apbAccess(1'b0, addr, 32'h0, d, err);
    expectEq("pslverr unmapped read", 32'(err), 32'd1);
    readReg(traceCfgPkg::RegCtrl, d);
    expectEq("CTRL after unmapped", d, 32'h0F);
    writeReg(traceCfgPkg::RegCtrl, 32'h0);
    finishTest("register access", e0);
  endtask

  task automatic testSingleCore();
    int e0;
    e0 = errors;
    writeReg(traceCfgPkg::RegCtrl, 32'h07);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    pulseTrace(1'b0, 2'b01);
    @(negedge clk);
    expectEq("o_active[0]", 32'(active[0]), 32'd1);
    for (int i = 0; i < 10; i++) driveRetires(2'b01, i);
    pulseTrace(1'b1, 2'b01);
    @(negedge clk);
    expectEq("o_active[0]", 32'(active[0]), 32'd0);
    waitWritePtr(12, 1'b0);
    readBuffer(12);
    buildExpected(0, 10);
    checkCore(0);
    finishTest("single core stall", e0);
  endtask

  task automatic testDualStall();
    int                   e0;
    logic [31:0]          d;
    traceCfgPkg::status_t st;
    e0 = errors;
    writeReg(traceCfgPkg::RegCtrl, 32'h0F);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    pulseTrace(1'b0, 2'b11);
    for (int i = 0; i < 12; i++) driveRetires(2'b11, i);
    pulseTrace(1'b1, 2'b11);
    waitWritePtr(28, 1'b0);
    readBuffer(28);
    for (int c = 0; c < NumCores; c++) begin
      buildExpected(c, 12);
      checkCore(c);
    end
    readReg(traceCfgPkg::RegStatus, d);
    st = traceCfgPkg::status_t'(d);
    expectEq("overflow", 32'(st.overflow), 32'd0);
    finishTest("dual core stall", e0);
  endtask

  task automatic testDropMode();
    int                   e0;
    int                   n;
    int                   j;
    int                   instrs;
    logic                 found;
    traceCfgPkg::status_t st;
    e0 = errors;
    n  = 16;
    writeReg(traceCfgPkg::RegCtrl, 32'h0D);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    pulseTrace(1'b0, 2'b11);
    // Back-to-back reports, one per cycle on both cores
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      for (int c = 0; c < NumCores; c++) retire[c] <= mkRetire(typeOf(c, i), addrOf(c, i));
    end
    @(posedge clk);
    retire <= '0;
    pulseTrace(1'b1, 2'b11);
    waitSettled(st);
    readBuffer(int'(st.writePtr));
    for (int c = 0; c < NumCores; c++) begin
      j      = 0;
      instrs = 0;
      foreach (got[k]) begin
        if (int'(got[k].coreId) == c && got[k].kind == tracePktPkg::KindInstr) begin
          instrs++;
          found = 1'b0;
          while (j < n && !found) begin
            if (got[k] == mkPkt(c, tracePktPkg::KindInstr, typeOf(c, j), addrOf(c, j)))
              found = 1'b1;
            j++;
          end
          if (!found) begin
            errors++;
            $display("Core %0d stored packet %h is out of order or never sent", c, got[k]);
          end
        end
      end
      expectEq("overflow bit", 32'(st.overflow[c]), 32'(instrs < n));
    end
    finishTest("drop mode", e0);
  endtask

  task automatic testWrapClear();
    int          e0;
    logic [31:0] d;
    e0 = errors;
    writeReg(traceCfgPkg::RegCtrl, 32'h07);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    pulseTrace(1'b0, 2'b01);
    for (int i = 0; i < 68; i++) driveRetires(2'b01, i);
    pulseTrace(1'b1, 2'b01);
    waitWritePtr(70 % BufDepth, 1'b1);
    readReg(traceCfgPkg::RegStatus, d);
    expectEq("STATUS after wrap", d, 32'h0001_0006);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    readReg(traceCfgPkg::RegStatus, d);
    expectEq("STATUS after clear", d, 32'd0);
    finishTest("wrap and clear", e0);
  endtask

  task automatic testDisabledCore();
    int                   e0;
    traceCfgPkg::status_t st;
    e0 = errors;
    writeReg(traceCfgPkg::RegCtrl, 32'h07);
    writeReg(traceCfgPkg::RegClear, 32'h0);
    pulseTrace(1'b0, 2'b10);
    @(negedge clk);
    expectEq("o_active[1]", 32'(active[1]), 32'd0);
    for (int i = 0; i < 5; i++) driveRetires(2'b10, i);
    pulseTrace(1'b1, 2'b10);
    waitSettled(st);
    expectEq("writePtr", 32'(st.writePtr), 32'd0);
    finishTest("disabled core", e0);
  endtask

  initial begin
    clk        = 1'b0;
    arstN      = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    traceStart = '0;
    traceStop  = '0;
    retire     = '0;
    errors     = 0;
    checks     = 0;
    testsRun   = 0;
    cycles     = 0;
    seed       = 40;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
    if (bp != '0 || active != '0) begin
      errors++;
      $display("Backpressure or active set right after reset");
    end
    testRegisters();
    testSingleCore();
    testDualStall();
    testDropMode();
    testWrapClear();
    testDisabledCore();
    $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/dfdTop_checker.sv
// **********************************************************
// Funnel assertions, bound into every traceFunnel instance
// **********************************************************
`timescale 1ns/100ps

module dfdTop_checker #(
  parameter int NumCores = 2,
  parameter int Credits  = 4,
  localparam int CntWidth = $clog2(Credits + 1)
) (
  input logic                              i_clk,
  input logic                              i_arstN,
  input logic [NumCores-1:0]               i_pktValid,
  input logic [NumCores-1:0][CntWidth-1:0] i_fifoCnt,
  input logic [NumCores-1:0]               i_credit,
  input logic                              i_outValid
);

  localparam int HeldWidth = CntWidth + 1;

  // Packets pushed minus credits returned, per source
  logic [NumCores-1:0][HeldWidth-1:0] held;

  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      held <= '0;
    end else begin
      for (int s = 0; s < NumCores; s++) begin
        held[s] <= held[s] + HeldWidth'(i_pktValid[s]) - HeldWidth'(i_credit[s]);
      end
    end
  end

  for (genvar s = 0; s < NumCores; s++) begin : g_src
    // Credits must keep every source FIFO from overflowing
    pushNotFull: assert property (@(posedge i_clk) disable iff (!i_arstN)
      i_pktValid[s] |-> (i_fifoCnt[s] != CntWidth'(Credits)))
      else $error("push into full FIFO of source %0d", s);

    creditPerPop: assert property (@(posedge i_clk) disable iff (!i_arstN)
      i_credit[s] |-> (held[s] != '0))
      else $error("credit pulse on source %0d with no packet left to return", s);
  end

  quietInReset: assert property (@(posedge i_clk) !i_arstN |-> !i_outValid)
    else $error("funnel output valid during reset");

endmodule

bind traceFunnel dfdTop_checker #(
  .NumCores(NumCores),
  .Credits (Credits)
) u_checker (
  .i_clk     (i_clk),
  .i_arstN   (i_arstN),
  .i_pktValid(i_pktValid),
  .i_fifoCnt (fifoCnt),
  .i_credit  (o_credit),
  .i_outValid(o_pktValid)
);
